/* rtl/usrp_ctrl_pkg.sv */
// Radio master control definitions
package usrp_ctrl_pkg;

  // Settings bus addresses of the four decoded registers
  localparam logic [6:0] ADDR_MASTER_CTRL     = 7'd0;
  localparam logic [6:0] ADDR_INTERP_RATE     = 7'd1;
  localparam logic [6:0] ADDR_DECIM_RATE      = 7'd2;
  localparam logic [6:0] ADDR_RX_MASTER_SLAVE = 7'd64;

  // Bit positions inside the 16-bit master control value
  localparam int unsigned BIT_ENABLE_TX    = 0;
  localparam int unsigned BIT_ENABLE_RX    = 1;
  localparam int unsigned BIT_TX_DSP_RESET = 2;
  localparam int unsigned BIT_RX_DSP_RESET = 3;
  // Switches the readback registers over to the debug inputs
  localparam int unsigned BIT_DEBUG_EN     = 4;

  // Bit positions inside the 16-bit master/slave value
  // Software sync request, acts on its own
  localparam int unsigned BIT_RX_SYNC        = 0;
  // Drive the sync level out on bit 15 of readback register 1
  localparam int unsigned BIT_RX_SYNC_MASTER = 1;
  // Let the hardware slave sync input through to sync_rx
  localparam int unsigned BIT_RX_SYNC_SLAVE  = 2;

  // The 32-bit settings data word has two readings
  // Rate registers take the raw word and keep its low byte
  // Masked registers see a write mask in the upper half and the value below it
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [15:0] mask;
      logic [15:0] value;
    } masked;
  } settings_word_u;

  // One broadcast settings bus transfer
  // The strobe is a single-cycle pulse and there is exactly one writer
  typedef struct packed {
    logic           strobe;
    logic [6:0]     addr;
    settings_word_u data;
  } settings_bus_t;

  // Control levels decoded from the master control value
  // Field order puts enable_tx at bit 0 so that the packed form lines up
  // with the bit positions above
  typedef struct packed {
    logic debug_en;
    logic rx_dsp_reset;
    logic tx_dsp_reset;
    logic enable_rx;
    logic enable_tx;
  } ctrl_t;

endpackage

/* rtl/setting_reg_masked.sv */
// Masked settings register
`timescale 1ns/1ps

module setting_reg_masked #(
  parameter logic [6:0] reg_addr = 7'd0
) (
  input  logic                         master_clk,
  input  logic                         rst_n,
  input  usrp_ctrl_pkg::settings_bus_t sbus,
  output logic [15:0]                  out
);

  // Address match for this register on the shared bus
  logic hit;
  // Value after merging the incoming write under its mask
  logic [15:0] merged;

  assign hit = sbus.strobe && (sbus.addr == reg_addr);

  // Bits with a set mask bit take the new value and all others hold
  assign merged = (out & ~sbus.data.masked.mask) |
                  (sbus.data.masked.value & sbus.data.masked.mask);

  // New value shows up in the cycle after the strobe
  always_ff @(posedge master_clk) begin
    if (!rst_n) begin
      out <= '0;
    end else if (hit) begin
      out <= merged;
    end
  end

endmodule

/* rtl/rate_strobe_gen.sv */
// Rate strobe generator
`timescale 1ns/1ps

module rate_strobe_gen (
  input  logic       master_clk,
  input  logic       rst_n,
  input  logic       enable,
  input  logic       dsp_reset,
  input  logic [7:0] rate,
  output logic       strobe
);

  // Cycles left until the next strobe
  logic [7:0] count;
  // Generator runs only while enabled and out of DSP reset
  logic active;

  assign active = enable && !dsp_reset;

  // The counter sits at rate while idle, so the first pulse comes
  // rate plus one cycles after the generator becomes active
  always_ff @(posedge master_clk) begin
    if (!rst_n) begin
      count  <= '0;
      strobe <= 1'b0;
    end else if (!active) begin
      count  <= rate;
      strobe <= 1'b0;
    end else if (count == 8'd0) begin
      // Reload on expiry so pulses repeat every rate plus one cycles
      count  <= rate;
      strobe <= 1'b1;
    end else begin
      count  <= count - 8'd1;
      strobe <= 1'b0;
    end
  end

endmodule

/* rtl/master_control.sv */
// Master control block
`timescale 1ns/1ps

module master_control (
  input  logic                         master_clk,
  input  logic                         rst_n,
  input  usrp_ctrl_pkg::settings_bus_t sbus,
  input  logic                         tx_empty,
  input  logic [15:0]                  debug_0,
  input  logic [15:0]                  debug_1,
  input  logic [15:0]                  debug_2,
  input  logic [15:0]                  debug_3,
  // Master/slave value held in the wrapper, shown on reg_3
  input  logic [15:0]                  ms_value,
  output usrp_ctrl_pkg::ctrl_t         ctrl,
  output logic [7:0]                   interp_rate,
  output logic [7:0]                   decim_rate,
  output logic                         strobe_interp,
  output logic                         strobe_decim,
  output logic [15:0]                  reg_0,
  output logic [15:0]                  reg_1,
  output logic [15:0]                  reg_2,
  output logic [15:0]                  reg_3
);

  import usrp_ctrl_pkg::*;

  // Zero padding between tx_empty and the control bits in reg_1
  localparam int unsigned PAD_W = 15 - $bits(ctrl_t);

  // Raw master control value
  logic [15:0] mc_value;

  setting_reg_masked #(
    .reg_addr (ADDR_MASTER_CTRL)
  ) master_ctrl_reg_i (
    .master_clk (master_clk),
    .rst_n      (rst_n),
    .sbus       (sbus),
    .out        (mc_value)
  );

  // Rate registers are whole-word writes that keep the low byte
  always_ff @(posedge master_clk) begin
    if (!rst_n) begin
      interp_rate <= '0;
      decim_rate  <= '0;
    end else if (sbus.strobe) begin
      if (sbus.addr == ADDR_INTERP_RATE) begin
        interp_rate <= sbus.data.raw[7:0];
      end
      if (sbus.addr == ADDR_DECIM_RATE) begin
        decim_rate <= sbus.data.raw[7:0];
      end
    end
  end

  // Control levels come straight from the register bits
  assign ctrl.enable_tx    = mc_value[BIT_ENABLE_TX];
  assign ctrl.enable_rx    = mc_value[BIT_ENABLE_RX];
  assign ctrl.tx_dsp_reset = mc_value[BIT_TX_DSP_RESET];
  assign ctrl.rx_dsp_reset = mc_value[BIT_RX_DSP_RESET];
  assign ctrl.debug_en     = mc_value[BIT_DEBUG_EN];

  // Transmit side paces the interpolator
  rate_strobe_gen interp_strobe_i (
    .master_clk (master_clk),
    .rst_n      (rst_n),
    .enable     (ctrl.enable_tx),
    .dsp_reset  (ctrl.tx_dsp_reset),
    .rate       (interp_rate),
    .strobe     (strobe_interp)
  );

  // Receive side paces the decimator
  rate_strobe_gen decim_strobe_i (
    .master_clk (master_clk),
    .rst_n      (rst_n),
    .enable     (ctrl.enable_rx),
    .dsp_reset  (ctrl.rx_dsp_reset),
    .rate       (decim_rate),
    .strobe     (strobe_decim)
  );

  // Readback mux, status words by default and debug inputs on request
  always_comb begin
    if (ctrl.debug_en) begin
      reg_0 = debug_0;
      reg_1 = debug_1;
      reg_2 = debug_2;
      reg_3 = debug_3;
    end else begin
      // Both rates packed into one word, interpolation in the high byte
      reg_0 = {interp_rate, decim_rate};
      // FIFO status on top and decoded controls in the low bits
      reg_1 = {tx_empty, {PAD_W{1'b0}}, ctrl};
      reg_2 = mc_value;
      reg_3 = ms_value;
    end
  end

endmodule

/* rtl/master_control_multi.sv */
// Multi-unit master control
`timescale 1ns/1ps

module master_control_multi (
  input  logic                         master_clk,
  input  logic                         rst_n,
  input  usrp_ctrl_pkg::settings_bus_t sbus,
  input  logic                         tx_empty,
  input  logic [15:0]                  debug_0,
  input  logic [15:0]                  debug_1,
  input  logic [15:0]                  debug_2,
  input  logic [15:0]                  debug_3,
  // Hardware sync from a master unit
  input  logic                         rx_slave_sync,
  output logic                         enable_tx,
  output logic                         enable_rx,
  output logic                         tx_dsp_reset,
  output logic                         rx_dsp_reset,
  output logic [7:0]                   interp_rate,
  output logic [7:0]                   decim_rate,
  output logic                         strobe_interp,
  output logic                         strobe_decim,
  output logic                         sync_rx,
  output logic [15:0]                  reg_0,
  output logic [15:0]                  reg_1,
  output logic [15:0]                  reg_2,
  output logic [15:0]                  reg_3
);

  import usrp_ctrl_pkg::*;

  ctrl_t       ctrl;
  // Readback word 1 before the sync override
  logic [15:0] reg_1_std;
  // Master/slave setting
  logic [15:0] ms_value;

  master_control master_control_i (
    .master_clk    (master_clk),
    .rst_n         (rst_n),
    .sbus          (sbus),
    .tx_empty      (tx_empty),
    .debug_0       (debug_0),
    .debug_1       (debug_1),
    .debug_2       (debug_2),
    .debug_3       (debug_3),
    .ms_value      (ms_value),
    .ctrl          (ctrl),
    .interp_rate   (interp_rate),
    .decim_rate    (decim_rate),
    .strobe_interp (strobe_interp),
    .strobe_decim  (strobe_decim),
    .reg_0         (reg_0),
    .reg_1         (reg_1_std),
    .reg_2         (reg_2),
    .reg_3         (reg_3)
  );

  setting_reg_masked #(
    .reg_addr (ADDR_RX_MASTER_SLAVE)
  ) ms_reg_i (
    .master_clk (master_clk),
    .rst_n      (rst_n),
    .sbus       (sbus),
    .out        (ms_value)
  );

  assign enable_tx    = ctrl.enable_tx;
  assign enable_rx    = ctrl.enable_rx;
  assign tx_dsp_reset = ctrl.tx_dsp_reset;
  assign rx_dsp_reset = ctrl.rx_dsp_reset;

  // Sync on software request, or on the hardware input when slaved
  // The slave path is combinational so it follows rx_slave_sync at once
  assign sync_rx = ms_value[BIT_RX_SYNC] |
                   (ms_value[BIT_RX_SYNC_SLAVE] & rx_slave_sync);

  // A master unit exports its sync level on bit 15 of reg_1
  // This override wins over the debug selection too
  assign reg_1 = {ms_value[BIT_RX_SYNC_MASTER] ? sync_rx : reg_1_std[15],
                  reg_1_std[14:0]};

endmodule

/* dv/tb_master_control.sv */
// Master control testbench
`timescale 1ns/1ps

module tb_master_control;

  import usrp_ctrl_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 2;
  localparam int NUM_WRITES   = 40;
  localparam int RATE_ROUNDS  = 4;
  localparam int HOLD_CYCLES  = 70;
  localparam int SYNC_CYCLES  = 16;
  // Rates are kept below 64 so three pulses fit in 4 * 64 cycles
  localparam int TEST_CYCLES  = RESET_CYCLES + 4 + 2 * NUM_WRITES +
                                RATE_ROUNDS * (8 + 4 * 64 + 2 * (HOLD_CYCLES + 2)) +
                                4 * (2 + SYNC_CYCLES) + 4 * (4 + SYNC_CYCLES);
  localparam int MARGIN       = 200;

  // Starts low before any process runs so time zero has no clock edge
  logic          master_clk = 1'b0;
  logic          rst_n;
  settings_bus_t sbus;
  logic          tx_empty;
  logic [15:0]   debug_0;
  logic [15:0]   debug_1;
  logic [15:0]   debug_2;
  logic [15:0]   debug_3;
  logic          rx_slave_sync;
  logic          enable_tx;
  logic          enable_rx;
  logic          tx_dsp_reset;
  logic          rx_dsp_reset;
  logic [7:0]    interp_rate;
  logic [7:0]    decim_rate;
  logic          strobe_interp;
  logic          strobe_decim;
  logic          sync_rx;
  logic [15:0]   reg_0;
  logic [15:0]   reg_1;
  logic [15:0]   reg_2;
  logic [15:0]   reg_3;

  // Register model of the four settings registers
  logic [15:0] mc_m = '0;
  logic [15:0] ms_m = '0;
  logic [7:0]  interp_m = '0;
  logic [7:0]  decim_m = '0;
  // Cycles since the last pulse and the pulse count of each strobe
  // Index 0 is the tx side and index 1 the rx side
  int          since_q [2];
  int          pulses_q [2];
  integer      seed = 75;

  master_control_multi dut_i (
    .master_clk    (master_clk),
    .rst_n         (rst_n),
    .sbus          (sbus),
    .tx_empty      (tx_empty),
    .debug_0       (debug_0),
    .debug_1       (debug_1),
    .debug_2       (debug_2),
    .debug_3       (debug_3),
    .rx_slave_sync (rx_slave_sync),
    .enable_tx     (enable_tx),
    .enable_rx     (enable_rx),
    .tx_dsp_reset  (tx_dsp_reset),
    .rx_dsp_reset  (rx_dsp_reset),
    .interp_rate   (interp_rate),
    .decim_rate    (decim_rate),
    .strobe_interp (strobe_interp),
    .strobe_decim  (strobe_decim),
    .sync_rx       (sync_rx),
    .reg_0         (reg_0),
    .reg_1         (reg_1),
    .reg_2         (reg_2),
    .reg_3         (reg_3)
  );

  always #(CLK_PERIOD / 2) master_clk = ~master_clk;

  function automatic logic [31:0] next_rand();
    next_rand = $random(seed);
  endfunction

  // Mask in the upper half selects which value bits are taken
  function automatic logic [15:0] merge_masked(input logic [15:0] old, input logic [31:0] word);
    return (old & ~word[31:16]) | (word[15:0] & word[31:16]);
  endfunction

  function automatic ctrl_t exp_ctrl(input logic [15:0] v);
    ctrl_t c;
    c.enable_tx    = v[BIT_ENABLE_TX];
    c.enable_rx    = v[BIT_ENABLE_RX];
    c.tx_dsp_reset = v[BIT_TX_DSP_RESET];
    c.rx_dsp_reset = v[BIT_RX_DSP_RESET];
    c.debug_en     = v[BIT_DEBUG_EN];
    return c;
  endfunction

  function automatic logic exp_sync();
    return ms_m[BIT_RX_SYNC] | (ms_m[BIT_RX_SYNC_SLAVE] & rx_slave_sync);
  endfunction

  function automatic logic [15:0] exp_readback(input int idx);
    logic [15:0] w;
    ctrl_t       c;
    c = exp_ctrl(mc_m);
    if (c.debug_en) begin
      case (idx)
        0: w = debug_0;
        1: w = debug_1;
        2: w = debug_2;
        default: w = debug_3;
      endcase
    end else begin
      case (idx)
        0: w = {interp_m, decim_m};
        1: begin
          w = 16'h0000;
          w[15] = tx_empty;
          w[BIT_ENABLE_TX] = c.enable_tx;
          w[BIT_ENABLE_RX] = c.enable_rx;
          w[BIT_TX_DSP_RESET] = c.tx_dsp_reset;
          w[BIT_RX_DSP_RESET] = c.rx_dsp_reset;
          w[BIT_DEBUG_EN] = c.debug_en;
        end
        2: w = mc_m;
        default: w = ms_m;
      endcase
    end
    // Sync master export wins over both readback sources
    if (idx == 1 && ms_m[BIT_RX_SYNC_MASTER]) begin
      w[15] = exp_sync();
    end
    return w;
  endfunction

  task automatic stop_on_error();
    $display("Simulation FAILED");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic check_ctrl(input string name, input ctrl_t expected, input ctrl_t actual);
    if (actual !== expected) begin
      $display("Mismatch %s: expected %b, actual %b", name, expected, actual);
      stop_on_error();
    end
  endtask

  task automatic check_word(input string name, input logic [15:0] expected,
                            input logic [15:0] actual);
    if (actual !== expected) begin
      $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
      stop_on_error();
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("Mismatch %s: expected %b, actual %b", name, expected, actual);
      stop_on_error();
    end
  endtask

  task automatic check_period(input string name, input int expected, input int actual);
    if (actual != expected) begin
      $display("Mismatch %s: expected gap %0d, actual gap %0d", name, expected, actual);
      stop_on_error();
    end
  endtask

  // A pulse is due every rate plus one active cycles on each strobe
  task automatic check_strobe(input int ch, input string name, input logic act,
                              input logic stb, input logic [7:0] rate);
    if (!act) begin
      check_bit({name, " idle"}, 1'b0, stb);
      since_q[ch] = 0;
    end else begin
      since_q[ch] = since_q[ch] + 1;
      if (stb || since_q[ch] > int'(rate) + 1) begin
        check_period(name, int'(rate) + 1, since_q[ch]);
        since_q[ch] = 0;
        pulses_q[ch] = pulses_q[ch] + 1;
      end
    end
  endtask

  // Inputs change mid cycle, so a registered path would still show the old value here
  task automatic check_comb_outputs();
    #1;
    check_bit("sync_rx comb", exp_sync(), sync_rx);
    check_word("reg_0 comb", exp_readback(0), reg_0);
    check_word("reg_1 comb", exp_readback(1), reg_1);
    check_word("reg_2 comb", exp_readback(2), reg_2);
    check_word("reg_3 comb", exp_readback(3), reg_3);
  endtask

  always @(posedge master_clk) begin : compare_outputs
    logic       act_tx;
    logic       act_rx;
    logic [7:0] rate_tx;
    logic [7:0] rate_rx;
    ctrl_t      seen;
    // Strobes leaving this edge depend on the register state before it
    act_tx  = rst_n & mc_m[BIT_ENABLE_TX] & ~mc_m[BIT_TX_DSP_RESET];
    act_rx  = rst_n & mc_m[BIT_ENABLE_RX] & ~mc_m[BIT_RX_DSP_RESET];
    rate_tx = interp_m;
    rate_rx = decim_m;
    if (!rst_n) begin
      mc_m     = '0;
      ms_m     = '0;
      interp_m = '0;
      decim_m  = '0;
    end else if (sbus.strobe) begin
      if (sbus.addr == ADDR_MASTER_CTRL) mc_m = merge_masked(mc_m, sbus.data.raw);
      if (sbus.addr == ADDR_RX_MASTER_SLAVE) ms_m = merge_masked(ms_m, sbus.data.raw);
      if (sbus.addr == ADDR_INTERP_RATE) interp_m = sbus.data.raw[7:0];
      if (sbus.addr == ADDR_DECIM_RATE) decim_m = sbus.data.raw[7:0];
    end
    // Registered outputs settle just after the edge
    #1;
    // debug_en has no pin and is seen through the readback mux instead
    seen.debug_en     = mc_m[BIT_DEBUG_EN];
    seen.enable_tx    = enable_tx;
    seen.enable_rx    = enable_rx;
    seen.tx_dsp_reset = tx_dsp_reset;
    seen.rx_dsp_reset = rx_dsp_reset;
    check_ctrl("ctrl levels", exp_ctrl(mc_m), seen);
    check_word("interp_rate", {8'h00, interp_m}, {8'h00, interp_rate});
    check_word("decim_rate", {8'h00, decim_m}, {8'h00, decim_rate});
    check_bit("sync_rx", exp_sync(), sync_rx);
    check_word("reg_0", exp_readback(0), reg_0);
    check_word("reg_1", exp_readback(1), reg_1);
    check_word("reg_2", exp_readback(2), reg_2);
    check_word("reg_3", exp_readback(3), reg_3);
    check_strobe(0, "strobe_interp", act_tx, strobe_interp, rate_tx);
    check_strobe(1, "strobe_decim", act_rx, strobe_decim, rate_rx);
  end

  // One strobed settings write, lasting a single cycle
  task automatic bus_write(input logic [6:0] addr, input logic [31:0] data);
    @(negedge master_clk);
    sbus.strobe   = 1'b1;
    sbus.addr     = addr;
    sbus.data.raw = data;
    @(negedge master_clk);
    sbus.strobe = 1'b0;
  endtask

  task automatic randomize_inputs();
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    r0 = next_rand();
    r1 = next_rand();
    r2 = next_rand();
    debug_0       = r0[15:0];
    debug_1       = r0[31:16];
    debug_2       = r1[15:0];
    debug_3       = r1[31:16];
    tx_empty      = r2[0];
    rx_slave_sync = r2[1];
  endtask

  initial begin : watchdog
    #(CLK_PERIOD * (TEST_CYCLES + MARGIN));
    $display("Timeout: the tests did not finish within the expected run time");
    $display("Simulation FAILED");
    $fatal(1, "Watchdog expired");
  end

  initial begin : stimulus
    logic [31:0] r;
    logic [6:0]  addr;
    logic [15:0] mask;
    logic [15:0] value;
    int          p0;
    int          p1;
    rst_n         = 1'b0;
    sbus          = '0;
    tx_empty      = 1'b0;
    debug_0       = '0;
    debug_1       = '0;
    debug_2       = '0;
    debug_3       = '0;
    rx_slave_sync = 1'b0;
    repeat (RESET_CYCLES) @(negedge master_clk);
    rst_n = 1'b1;

    // Everything starts cleared
    repeat (2) @(negedge master_clk);
    check_word("reset rates", 16'h0000, {interp_rate, decim_rate});
    check_word("reset levels", 16'h0000, {9'd0, enable_tx, enable_rx, tx_dsp_reset,
               rx_dsp_reset, strobe_interp, strobe_decim, sync_rx});

    // Masked writes to both masked registers and to unused addresses
    for (int i = 0; i < NUM_WRITES; i++) begin
      r = next_rand();
      case (r[2:0])
        3'd0, 3'd1, 3'd2: addr = ADDR_MASTER_CTRL;
        3'd3, 3'd4, 3'd5: addr = ADDR_RX_MASTER_SLAVE;
        3'd6: addr = 7'd5;
        default: addr = 7'd99;
      endcase
      randomize_inputs();
      bus_write(addr, next_rand());
    end

    // Strobe spacing with random rates, then held in reset, then disabled
    for (int n = 0; n < RATE_ROUNDS; n++) begin
      bus_write(ADDR_MASTER_CTRL, 32'h001F_0000);
      r = next_rand();
      bus_write(ADDR_INTERP_RATE, {26'd0, r[5:0]});
      bus_write(ADDR_DECIM_RATE, {26'd0, r[13:8]});
      p0 = pulses_q[0];
      p1 = pulses_q[1];
      bus_write(ADDR_MASTER_CTRL, 32'h000F_0003);
      wait (pulses_q[0] >= p0 + 3 && pulses_q[1] >= p1 + 3);
      bus_write(ADDR_MASTER_CTRL, 32'h000C_000C);
      repeat (HOLD_CYCLES) @(negedge master_clk);
      bus_write(ADDR_MASTER_CTRL, 32'h000F_0000);
      repeat (HOLD_CYCLES) @(negedge master_clk);
    end

    // Every pairing of the sync bit and the slave enable
    for (int c = 0; c < 4; c++) begin
      mask  = 16'h0000;
      value = 16'h0000;
      mask[BIT_RX_SYNC]        = 1'b1;
      mask[BIT_RX_SYNC_SLAVE]  = 1'b1;
      value[BIT_RX_SYNC]       = c[0];
      value[BIT_RX_SYNC_SLAVE] = c[1];
      bus_write(ADDR_RX_MASTER_SLAVE, {mask, value});
      repeat (SYNC_CYCLES) begin
        @(negedge master_clk);
        randomize_inputs();
        check_comb_outputs();
      end
    end

    // Readback with and without debug_en, with and without sync master
    for (int c = 0; c < 4; c++) begin
      mask  = 16'h0000;
      value = 16'h0000;
      mask[BIT_DEBUG_EN]  = 1'b1;
      value[BIT_DEBUG_EN] = c[0];
      bus_write(ADDR_MASTER_CTRL, {mask, value});
      r = next_rand();
      mask  = 16'h0000;
      value = r[15:0];
      mask[BIT_RX_SYNC]        = 1'b1;
      mask[BIT_RX_SYNC_SLAVE]  = 1'b1;
      mask[BIT_RX_SYNC_MASTER] = 1'b1;
      value[BIT_RX_SYNC_MASTER] = c[1];
      bus_write(ADDR_RX_MASTER_SLAVE, {mask, value});
      repeat (SYNC_CYCLES) begin
        @(negedge master_clk);
        randomize_inputs();
        check_comb_outputs();
      end
    end

    @(negedge master_clk);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

/* verilog.f */
rtl/usrp_ctrl_pkg.sv
rtl/setting_reg_masked.sv
rtl/rate_strobe_gen.sv
rtl/master_control.sv
rtl/master_control_multi.sv
dv/tb_master_control.sv

/* Makefile */
# Verilator build and run for the master control testbench

VERILATOR ?= verilator
TOP       ?= tb_master_control
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_TEXT ?= Simulation PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Fails unless the pass message shows up in the output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
